// File: src.f
+incdir+include
source/intm_pkg.sv
source/intm_prf.sv
source/intm_rs.sv
source/fu_mul.sv
source/fu_div.sv
source/intm_cdb_stage.sv
source/intm_unit.sv
tb/tb_clock.sv
tb/intm_unit_tb.sv

// File: Bender.yml
package:
  name: intm_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/intm_pkg.sv
      - source/intm_prf.sv
      - source/intm_rs.sv
      - source/fu_mul.sv
      - source/fu_div.sv
      - source/intm_cdb_stage.sv
      - source/intm_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clock.sv
      - tb/intm_unit_tb.sv

// File: tb/intm_unit_tb.sv
`default_nettype none

`include "intm_settings.svh"

module intm_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import intm_pkg::*;

    localparam int XLEN  = `INTM_XLEN;
    localparam int ROBS  = 1 << `INTM_ROB_W;
    localparam int DRIVE = 2;

    // op word, div flag on top
    localparam logic [2:0] OP_MUL    = 3'b000;
    localparam logic [2:0] OP_MULH   = 3'b001;
    localparam logic [2:0] OP_MULHSU = 3'b010;
    localparam logic [2:0] OP_MULHU  = 3'b011;
    localparam logic [2:0] OP_DIV    = 3'b100;
    localparam logic [2:0] OP_DIVU   = 3'b101;
    localparam logic [2:0] OP_REM    = 3'b110;
    localparam logic [2:0] OP_REMU   = 3'b111;

    logic            clk;
    logic            rst;
    logic            dispatch_valid;
    rob_t            dispatch_rob;
    phy_t            dispatch_rs1;
    logic            dispatch_rs1_rdy;
    phy_t            dispatch_rs2;
    logic            dispatch_rs2_rdy;
    phy_t            dispatch_rd;
    intm_op_t        dispatch_op;
    logic            dispatch_ready;
    logic            ext_wb_valid;
    phy_t            ext_wb_phy;
    logic [XLEN-1:0] ext_wb_value;
    logic            cdb_valid;
    rob_t            cdb_rob;
    phy_t            cdb_phy;
    logic [XLEN-1:0] cdb_value;

    // reference model state, indexed by register or rob id
    logic [XLEN-1:0] model_regs [`INTM_PRF_DEPTH];
    logic [2:0]      rec_op     [ROBS];
    logic [XLEN-1:0] rec_a      [ROBS];
    logic [XLEN-1:0] rec_b      [ROBS];
    phy_t            rec_rd     [ROBS];
    phy_t            rec_tag    [ROBS];
    logic            pending    [ROBS];
    logic            blocked    [ROBS];
    int              held_count;
    int              outstanding;
    int              results_seen;
    int              check_errors;
    int              timeout_errors;
    logic            idle_check;
    logic [15:0]     lfsr_state;
    rob_t            next_rob;

    tb_clock clock_gen (.clk(clk));

    intm_unit dut (.*);

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // RISC-V M-extension semantics
    function automatic logic [XLEN-1:0] model_result(input logic [2:0] op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] a_s;
        logic [2*XLEN-1:0] a_u;
        logic [2*XLEN-1:0] b_s;
        logic [2*XLEN-1:0] b_u;
        logic [2*XLEN-1:0] prod;
        logic [XLEN-1:0]   res;
        logic              overflow;
        logic signed [XLEN-1:0] quo_s;
        logic signed [XLEN-1:0] rem_s;
        a_s      = {{XLEN{a[XLEN-1]}}, a};
        a_u      = {{XLEN{1'b0}}, a};
        b_s      = {{XLEN{b[XLEN-1]}}, b};
        b_u      = {{XLEN{1'b0}}, b};
        overflow = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
        // signed quotient and remainder outside the corner cases
        quo_s = '0;
        rem_s = '0;
        if (b != '0 && !overflow) begin
            quo_s = $signed(a) / $signed(b);
            rem_s = $signed(a) % $signed(b);
        end
        case (op)
            OP_MULH:   prod = a_s * b_s;
            OP_MULHSU: prod = a_s * b_u;
            default:   prod = a_u * b_u;
        endcase
        case (op)
            OP_MUL:  res = prod[XLEN-1:0];
            OP_DIV:  res = (b == '0) ? '1 : overflow ? a : quo_s;
            OP_REM:  res = (b == '0) ? a : overflow ? '0 : rem_s;
            OP_DIVU: res = (b == '0) ? '1 : a / b;
            OP_REMU: res = (b == '0) ? a : a % b;
            default: res = prod[2*XLEN-1:XLEN];
        endcase
        return res;
    endfunction

    function automatic void flag_mismatch(input string msg);
        check_errors++;
        $display("FAIL %0t ns: %s", $time, msg);
    endfunction

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    assert property (@(posedge clk) disable iff (rst)
        idle_check |-> !cdb_valid && dispatch_ready)
        else flag_mismatch("bus active or station not ready while idle");

    assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> cdb_value == model_result(rec_op[cdb_rob], rec_a[cdb_rob], rec_b[cdb_rob]))
        else flag_mismatch($sformatf("rob %0d value %h wrong", $sampled(cdb_rob),
                                     $sampled(cdb_value)));

    assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> cdb_phy == rec_rd[cdb_rob])
        else flag_mismatch($sformatf("rob %0d wrote wrong register", $sampled(cdb_rob)));

    // each rob id comes back once, and only after dispatch
    assert property (@(posedge clk) disable iff (rst) cdb_valid |-> pending[cdb_rob])
        else flag_mismatch($sformatf("unexpected result for rob %0d", $sampled(cdb_rob)));

    assert property (@(posedge clk) disable iff (rst) cdb_valid |-> !blocked[cdb_rob])
        else flag_mismatch($sformatf("rob %0d finished before its source", $sampled(cdb_rob)));

    assert property (@(posedge clk) disable iff (rst)
        held_count >= `INTM_RS_DEPTH |-> !dispatch_ready)
        else flag_mismatch("dispatch_ready high with the station full");

    // results feed the model register file
    always @(posedge clk) begin
        if (!rst && cdb_valid) begin
            if (pending[cdb_rob]) begin
                pending[cdb_rob] = 1'b0;
                outstanding--;
            end
            model_regs[cdb_phy] = cdb_value;
            results_seen++;
        end
    end

    // ------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------

    task automatic next_cycle;
        @(posedge clk);
        #DRIVE;
    endtask

    task automatic write_reg(input phy_t phy, input logic [XLEN-1:0] value);
        ext_wb_valid    = 1'b1;
        ext_wb_phy      = phy;
        ext_wb_value    = value;
        model_regs[phy] = value;
        // waiting entries pick up the value they will issue with
        for (int r = 0; r < ROBS; r++) begin
            if (pending[r] && blocked[r] && rec_tag[r] == phy) begin
                rec_a[r]   = value;
                blocked[r] = 1'b0;
                held_count--;
            end
        end
        next_cycle();
        ext_wb_valid = 1'b0;
    endtask

    task automatic send_uop(input logic [2:0] op, input phy_t rs1, input logic rs1_rdy,
                            input phy_t rs2);
        int   waited;
        rob_t rob;
        waited = 0;
        rob    = next_rob;
        while (pending[rob] && waited < 500) begin
            next_cycle();
            waited++;
        end
        if (pending[rob]) begin
            timeout_errors++;
            $display("timeout: rob id %0d never came back", rob);
            return;
        end
        dispatch_valid   = 1'b1;
        dispatch_rob     = rob;
        dispatch_rs1     = rs1;
        dispatch_rs1_rdy = rs1_rdy;
        dispatch_rs2     = rs2;
        dispatch_rs2_rdy = 1'b1;
        dispatch_rd      = {1'b1, rob};
        dispatch_op      = intm_op_t'(op);
        waited = 0;
        while (!dispatch_ready && waited < 200) begin
            next_cycle();
            waited++;
        end
        if (!dispatch_ready) begin
            timeout_errors++;
            $display("timeout: station never accepted rob id %0d", rob);
            dispatch_valid = 1'b0;
            return;
        end
        rec_op[rob]  = op;
        rec_a[rob]   = model_regs[rs1];
        rec_b[rob]   = model_regs[rs2];
        rec_rd[rob]  = {1'b1, rob};
        rec_tag[rob] = rs1;
        blocked[rob] = !rs1_rdy;
        pending[rob] = 1'b1;
        outstanding++;
        next_rob = rob + 1'b1;
        next_cycle();
        dispatch_valid = 1'b0;
        // counted once resident in the station
        if (!rs1_rdy) begin
            held_count++;
        end
    endtask

    task automatic wait_drain;
        int waited;
        waited = 0;
        while (outstanding != 0 && waited < 1000) begin
            next_cycle();
            waited++;
        end
        if (outstanding != 0) begin
            timeout_errors++;
            $display("timeout: %0d results never arrived", outstanding);
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        logic [2:0] op;
        phy_t       rs1;
        phy_t       rs2;
        lfsr_state       = 16'd52554;
        rst              = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_rob     = '0;
        dispatch_rs1     = '0;
        dispatch_rs1_rdy = 1'b0;
        dispatch_rs2     = '0;
        dispatch_rs2_rdy = 1'b0;
        dispatch_rd      = '0;
        dispatch_op      = '0;
        ext_wb_valid     = 1'b0;
        ext_wb_phy       = '0;
        ext_wb_value     = '0;
        idle_check       = 1'b0;
        held_count       = 0;
        outstanding      = 0;
        results_seen     = 0;
        check_errors     = 0;
        timeout_errors   = 0;
        next_rob         = '0;
        for (int r = 0; r < ROBS; r++) begin
            pending[r] = 1'b0;
            blocked[r] = 1'b0;
            rec_op[r]  = '0;
            rec_a[r]   = '0;
            rec_b[r]   = '0;
            rec_rd[r]  = '0;
            rec_tag[r] = '0;
        end
        for (int p = 0; p < `INTM_PRF_DEPTH; p++) begin
            model_regs[p] = '0;
        end

        repeat (16) @(posedge clk);
        #DRIVE;
        rst = 1'b0;

        // quiet after reset
        idle_check = 1'b1;
        repeat (8) next_cycle();
        idle_check = 1'b0;

        // random ops, first batch walks all eight
        for (int batch = 0; batch < 4; batch++) begin
            for (int p = 0; p < 16; p++) begin
                write_reg(phy_t'(p), (p < 8) ? lfsr_bits(32) : lfsr_bits(8));
            end
            for (int k = 0; k < 8; k++) begin
                op  = (batch == 0) ? 3'(k) : 3'(lfsr_bits(3));
                rs1 = phy_t'(lfsr_bits(4));
                rs2 = phy_t'(lfsr_bits(4));
                send_uop(op, rs1, 1'b1, rs2);
            end
            wait_drain();
        end

        // divide by zero and signed overflow
        write_reg(phy_t'(16), {1'b1, {(XLEN-1){1'b0}}});
        write_reg(phy_t'(17), '1);
        write_reg(phy_t'(18), '0);
        write_reg(phy_t'(19), 32'd1234567);
        send_uop(OP_DIV, phy_t'(16), 1'b1, phy_t'(17));
        send_uop(OP_REM, phy_t'(16), 1'b1, phy_t'(17));
        send_uop(OP_DIV, phy_t'(19), 1'b1, phy_t'(18));
        send_uop(OP_REM, phy_t'(19), 1'b1, phy_t'(18));
        send_uop(OP_DIVU, phy_t'(19), 1'b1, phy_t'(18));
        send_uop(OP_REMU, phy_t'(19), 1'b1, phy_t'(18));
        send_uop(OP_DIVU, phy_t'(16), 1'b1, phy_t'(17));
        wait_drain();

        // operand not ready until written from outside
        write_reg(phy_t'(20), 32'd7);
        write_reg(phy_t'(21), 32'd3);
        send_uop(OP_MUL, phy_t'(20), 1'b0, phy_t'(21));
        send_uop(OP_DIV, phy_t'(20), 1'b0, phy_t'(21));
        repeat (40) next_cycle();
        write_reg(phy_t'(20), 32'hFFFF_FF9C);
        wait_drain();

        // fill the station, then release it
        write_reg(phy_t'(22), lfsr_bits(32));
        for (int k = 0; k < 4; k++) begin
            send_uop(OP_MULH, phy_t'(23), 1'b0, phy_t'(22));
        end
        repeat (4) next_cycle();
        write_reg(phy_t'(23), lfsr_bits(32));
        send_uop(OP_REMU, phy_t'(22), 1'b1, phy_t'(23));
        wait_drain();

        // multiplies stream into the divider's result slot
        write_reg(phy_t'(24), lfsr_bits(32));
        write_reg(phy_t'(25), lfsr_bits(16) | 32'd1);
        send_uop(OP_DIV, phy_t'(24), 1'b1, phy_t'(25));
        repeat (26) next_cycle();
        for (int k = 0; k < 12; k++) begin
            send_uop(3'(k % 4), phy_t'(24 + (k % 2)), 1'b1, phy_t'(25));
        end
        wait_drain();

        repeat (4) next_cycle();
        $display("results %0d, check errors %0d, timeouts %0d",
                 results_seen, check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 20
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: source/intm_unit.sv
`default_nettype none

`include "intm_settings.svh"

module intm_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  intm_pkg::rob_t        dispatch_rob,
    input  intm_pkg::phy_t        dispatch_rs1,
    input  logic                  dispatch_rs1_rdy,
    input  intm_pkg::phy_t        dispatch_rs2,
    input  logic                  dispatch_rs2_rdy,
    input  intm_pkg::phy_t        dispatch_rd,
    input  intm_pkg::intm_op_t    dispatch_op,
    output logic                  dispatch_ready,
    input  logic                  ext_wb_valid,
    input  intm_pkg::phy_t        ext_wb_phy,
    input  logic [`INTM_XLEN-1:0] ext_wb_value,
    output logic                  cdb_valid,
    output intm_pkg::rob_t        cdb_rob,
    output intm_pkg::phy_t        cdb_phy,
    output logic [`INTM_XLEN-1:0] cdb_value
);

    import intm_pkg::*;

    // ----------------------------------------------------------
    // station to register file and units
    // ----------------------------------------------------------

    phy_t                  rd1_phy;
    phy_t                  rd2_phy;
    logic [`INTM_XLEN-1:0] rd1_value;
    logic [`INTM_XLEN-1:0] rd2_value;
    logic                  mul_issue;
    logic                  div_issue;
    logic                  mul_ready;
    logic                  div_ready;
    rob_t                  iss_rob;
    phy_t                  iss_rd;
    intm_op_t              iss_op;
    logic [`INTM_XLEN-1:0] iss_a;
    logic [`INTM_XLEN-1:0] iss_b;

    // units to result stage
    logic                  mul_res_valid;
    logic                  div_res_valid;
    res_t                  mul_res;
    res_t                  div_res;
    logic                  mul_accept;
    logic                  div_accept;

    // port names line up across the cluster
    intm_prf       prf_i   (.*);
    intm_rs        rs_i    (.*);
    fu_mul         mul_i   (.*);
    fu_div         div_i   (.*);
    intm_cdb_stage cdb_i   (.*);

endmodule

`default_nettype wire

// File: source/intm_cdb_stage.sv
`default_nettype none

`include "intm_settings.svh"

module intm_cdb_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mul_res_valid,
    input  intm_pkg::res_t        mul_res,
    input  logic                  div_res_valid,
    input  intm_pkg::res_t        div_res,
    output logic                  mul_accept,
    output logic                  div_accept,
    output logic                  cdb_valid,
    output intm_pkg::rob_t        cdb_rob,
    output intm_pkg::phy_t        cdb_phy,
    output logic [`INTM_XLEN-1:0] cdb_value
);

    import intm_pkg::*;

    res_t cdb_q;

    // divider never waits, multiplier yields to it
    assign div_accept = 1'b1;
    assign mul_accept = !div_res_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= mul_res_valid || div_res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_res_valid || div_res_valid) begin
            cdb_q <= div_res_valid ? div_res : mul_res;
        end
    end

    assign cdb_rob   = cdb_q.rob;
    assign cdb_phy   = cdb_q.rd;
    assign cdb_value = cdb_q.value;

    assert property (@(posedge clk) disable iff (rst) !$isunknown(cdb_valid))
        else $error("cdb: valid is unknown");

endmodule

`default_nettype wire

// File: source/fu_div.sv
`default_nettype none

`include "intm_settings.svh"

module fu_div (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  div_issue,
    input  intm_pkg::rob_t        iss_rob,
    input  intm_pkg::phy_t        iss_rd,
    input  intm_pkg::intm_op_t    iss_op,
    input  logic [`INTM_XLEN-1:0] iss_a,
    input  logic [`INTM_XLEN-1:0] iss_b,
    output logic                  div_ready,
    output logic                  div_res_valid,
    output intm_pkg::res_t        div_res,
    input  logic                  div_accept
);

    import intm_pkg::*;

    localparam int XLEN = `INTM_XLEN;
    localparam int CW   = $clog2(XLEN);

    logic            busy;
    logic [CW-1:0]   count;
    logic            last;
    iss_t            job;
    logic [XLEN-1:0] quo;
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] dvsr;
    logic            neg_q;
    logic            neg_r;
    logic            div_zero;
    logic            a_neg;
    logic            b_neg;
    logic [XLEN:0]   trial;
    logic [XLEN-1:0] quo_next;
    logic [XLEN-1:0] rem_next;
    logic [XLEN-1:0] q_out;
    logic [XLEN-1:0] r_out;

    assign a_neg     = !iss_op.div.uns && iss_a[XLEN-1];
    assign b_neg     = !iss_op.div.uns && iss_b[XLEN-1];
    assign last      = busy && count == CW'(XLEN - 1);
    assign div_ready = !busy && (!div_res_valid || div_accept);

    // ----------------------------------------------------------
    // one restoring step per cycle on magnitudes
    // ----------------------------------------------------------

    assign trial    = {rem, quo[XLEN-1]} - {1'b0, dvsr};
    assign quo_next = {quo[XLEN-2:0], !trial[XLEN]};
    assign rem_next = trial[XLEN] ? {rem[XLEN-2:0], quo[XLEN-1]} : trial[XLEN-1:0];

    // most negative / -1 already lands on the dividend with zero remainder
    always_comb begin
        q_out = neg_q ? -quo_next : quo_next;
        r_out = neg_r ? -rem_next : rem_next;
        if (div_zero) begin
            q_out = '1;
            r_out = job.a;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy          <= 1'b0;
            count         <= '0;
            div_res_valid <= 1'b0;
        end else begin
            if (div_issue) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                busy  <= !last;
                count <= count + 1'b1;
            end
            if (last) begin
                div_res_valid <= 1'b1;
            end else if (div_accept) begin
                div_res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_issue) begin
            job      <= '{rob: iss_rob, rd: iss_rd, op: iss_op, a: iss_a, b: iss_b};
            quo      <= a_neg ? -iss_a : iss_a;
            rem      <= '0;
            dvsr     <= b_neg ? -iss_b : iss_b;
            neg_q    <= a_neg ^ b_neg;
            neg_r    <= a_neg;
            div_zero <= iss_b == '0;
        end else if (busy) begin
            quo <= quo_next;
            rem <= rem_next;
        end
        if (last) begin
            div_res.rob   <= job.rob;
            div_res.rd    <= job.rd;
            div_res.value <= job.op.div.rem ? r_out : q_out;
        end
    end

endmodule

`default_nettype wire

// File: source/fu_mul.sv
`default_nettype none

`include "intm_settings.svh"

module fu_mul (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mul_issue,
    input  intm_pkg::rob_t        iss_rob,
    input  intm_pkg::phy_t        iss_rd,
    input  intm_pkg::intm_op_t    iss_op,
    input  logic [`INTM_XLEN-1:0] iss_a,
    input  logic [`INTM_XLEN-1:0] iss_b,
    output logic                  mul_ready,
    output logic                  mul_res_valid,
    output intm_pkg::res_t        mul_res,
    input  logic                  mul_accept
);

    import intm_pkg::*;

    localparam int XLEN = `INTM_XLEN;

    logic                     advance;
    logic                     s1_valid;
    logic                     s2_valid;
    iss_t                     s1;
    logic                     a_signed;
    logic                     b_signed;
    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN+1:0] prod_full;
    logic [2*XLEN-1:0]        s2_prod;
    logic                     s2_hi;
    rob_t                     s2_rob;
    phy_t                     s2_rd;

    // whole pipe moves together or not at all
    assign advance   = !mul_res_valid || mul_accept;
    assign mul_ready = advance;

    always_comb begin
        case (s1.op.mul.kind)
            KIND_MULH: begin
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
            KIND_MULHSU: begin
                a_signed = 1'b1;
                b_signed = 1'b0;
            end
            KIND_MULHU: begin
                a_signed = 1'b0;
                b_signed = 1'b0;
            end
            default: begin
                a_signed = 1'b0;
                b_signed = 1'b0;
            end
        endcase
    end

    // one extra bit carries the sign choice into a signed multiply
    assign a_ext     = {a_signed && s1.a[XLEN-1], s1.a};
    assign b_ext     = {b_signed && s1.b[XLEN-1], s1.b};
    assign prod_full = a_ext * b_ext;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid      <= 1'b0;
            s2_valid      <= 1'b0;
            mul_res_valid <= 1'b0;
        end else if (advance) begin
            s1_valid      <= mul_issue;
            s2_valid      <= s1_valid;
            mul_res_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1            <= '{rob: iss_rob, rd: iss_rd, op: iss_op, a: iss_a, b: iss_b};
            s2_prod       <= prod_full[2*XLEN-1:0];
            s2_hi         <= s1.op.mul.kind != KIND_MUL;
            s2_rob        <= s1.rob;
            s2_rd         <= s1.rd;
            mul_res.rob   <= s2_rob;
            mul_res.rd    <= s2_rd;
            mul_res.value <= s2_hi ? s2_prod[2*XLEN-1:XLEN] : s2_prod[XLEN-1:0];
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        mul_res_valid && !mul_accept |=> mul_res_valid && $stable(mul_res))
        else $error("fu_mul: result changed while stalled");

endmodule

`default_nettype wire

// File: source/intm_rs.sv
`default_nettype none

`include "intm_settings.svh"

module intm_rs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  intm_pkg::rob_t        dispatch_rob,
    input  intm_pkg::phy_t        dispatch_rs1,
    input  logic                  dispatch_rs1_rdy,
    input  intm_pkg::phy_t        dispatch_rs2,
    input  logic                  dispatch_rs2_rdy,
    input  intm_pkg::phy_t        dispatch_rd,
    input  intm_pkg::intm_op_t    dispatch_op,
    output logic                  dispatch_ready,
    input  logic                  ext_wb_valid,
    input  intm_pkg::phy_t        ext_wb_phy,
    input  logic                  cdb_valid,
    input  intm_pkg::phy_t        cdb_phy,
    output intm_pkg::phy_t        rd1_phy,
    output intm_pkg::phy_t        rd2_phy,
    input  logic [`INTM_XLEN-1:0] rd1_value,
    input  logic [`INTM_XLEN-1:0] rd2_value,
    input  logic                  mul_ready,
    input  logic                  div_ready,
    output logic                  mul_issue,
    output logic                  div_issue,
    output intm_pkg::rob_t        iss_rob,
    output intm_pkg::phy_t        iss_rd,
    output intm_pkg::intm_op_t    iss_op,
    output logic [`INTM_XLEN-1:0] iss_a,
    output logic [`INTM_XLEN-1:0] iss_b
);

    import intm_pkg::*;

    localparam int DEPTH = `INTM_RS_DEPTH;

    logic      [DEPTH-1:0] entry_valid;
    rs_entry_t [DEPTH-1:0] entry;
    logic      [DEPTH-1:0] push;
    logic      [DEPTH-1:0] mul_req;
    logic      [DEPTH-1:0] div_req;
    logic      [DEPTH-1:0] mul_grant;
    logic      [DEPTH-1:0] div_grant;
    logic      [DEPTH-1:0] grant;
    rs_entry_t             sel;
    logic                  dispatch_fire;

    // tag seen on either result bus this cycle
    function automatic logic woken(input phy_t tag);
        return (ext_wb_valid && ext_wb_phy == tag) || (cdb_valid && cdb_phy == tag);
    endfunction

    // ----------------------------------------------------------
    // allocation
    // ----------------------------------------------------------

    assign dispatch_ready = ~&entry_valid;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    // walk down so the lowest free slot wins
    always_comb begin
        push = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                push    = '0;
                push[i] = dispatch_fire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else begin
            entry_valid <= (entry_valid & ~grant) | push;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (push[i]) begin
                entry[i].rob     <= dispatch_rob;
                entry[i].rs1     <= dispatch_rs1;
                entry[i].rs1_rdy <= dispatch_rs1_rdy || woken(dispatch_rs1);
                entry[i].rs2     <= dispatch_rs2;
                entry[i].rs2_rdy <= dispatch_rs2_rdy || woken(dispatch_rs2);
                entry[i].rd      <= dispatch_rd;
                entry[i].op      <= dispatch_op;
            end else begin
                entry[i].rs1_rdy <= entry[i].rs1_rdy || woken(entry[i].rs1);
                entry[i].rs2_rdy <= entry[i].rs2_rdy || woken(entry[i].rs2);
            end
        end
    end

    // ----------------------------------------------------------
    // issue select
    // ----------------------------------------------------------

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            mul_req[i] = entry_valid[i] && entry[i].rs1_rdy && entry[i].rs2_rdy
                         && !entry[i].op.div.is_div;
            div_req[i] = entry_valid[i] && entry[i].rs1_rdy && entry[i].rs2_rdy
                         && entry[i].op.div.is_div;
        end
    end

    always_comb begin
        mul_grant = '0;
        div_grant = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (mul_req[i] && mul_ready) begin
                mul_grant    = '0;
                mul_grant[i] = 1'b1;
            end
            if (div_req[i] && div_ready) begin
                div_grant    = '0;
                div_grant[i] = 1'b1;
            end
        end
    end

    // divide goes first, it holds its unit much longer
    assign div_issue = |div_grant;
    assign mul_issue = !div_issue && (|mul_grant);
    assign grant     = div_issue ? div_grant : mul_grant;

    always_comb begin
        sel = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (grant[i]) begin
                sel = entry[i];
            end
        end
    end

    assign rd1_phy = sel.rs1;
    assign rd2_phy = sel.rs2;
    assign iss_rob = sel.rob;
    assign iss_rd  = sel.rd;
    assign iss_op  = sel.op;
    assign iss_a   = rd1_value;
    assign iss_b   = rd2_value;

    assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("rs: more than one entry granted");

    // a taken micro-op lands in one free slot and is resident next cycle
    assert property (@(posedge clk) disable iff (rst)
        dispatch_fire |-> $onehot(push) ##1 |(entry_valid & $past(push)))
        else $error("rs: dispatch taken with no free entry");

endmodule

`default_nettype wire

// File: source/intm_prf.sv
`default_nettype none

`include "intm_settings.svh"

module intm_prf (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ext_wb_valid,
    input  intm_pkg::phy_t        ext_wb_phy,
    input  logic [`INTM_XLEN-1:0] ext_wb_value,
    input  logic                  cdb_valid,
    input  intm_pkg::phy_t        cdb_phy,
    input  logic [`INTM_XLEN-1:0] cdb_value,
    input  intm_pkg::phy_t        rd1_phy,
    input  intm_pkg::phy_t        rd2_phy,
    output logic [`INTM_XLEN-1:0] rd1_value,
    output logic [`INTM_XLEN-1:0] rd2_value
);

    import intm_pkg::*;

    logic [`INTM_XLEN-1:0] regs [`INTM_PRF_DEPTH];

    always_ff @(posedge clk) begin
        if (ext_wb_valid) begin
            regs[ext_wb_phy] <= ext_wb_value;
        end
        if (cdb_valid) begin
            regs[cdb_phy] <= cdb_value;
        end
    end

    // a write in flight this cycle beats the array
    function automatic logic [`INTM_XLEN-1:0] read_port(input phy_t p);
        if (cdb_valid && cdb_phy == p) begin
            return cdb_value;
        end
        if (ext_wb_valid && ext_wb_phy == p) begin
            return ext_wb_value;
        end
        return regs[p];
    endfunction

    always_comb begin
        rd1_value = read_port(rd1_phy);
        rd2_value = read_port(rd2_phy);
    end

    // rename never gives one register to two producers finishing together
    assert property (@(posedge clk) disable iff (rst)
        !(ext_wb_valid && cdb_valid && ext_wb_phy == cdb_phy))
        else $error("prf: both write ports hit register %0d", cdb_phy);

endmodule

`default_nettype wire

// File: source/intm_pkg.sv
`default_nettype none

`include "intm_settings.svh"

package intm_pkg;

    typedef logic [$clog2(`INTM_PRF_DEPTH)-1:0] phy_t;
    typedef logic [`INTM_ROB_W-1:0]             rob_t;

    // mul kind, low two bits of the M-extension funct3
    localparam logic [1:0] KIND_MUL    = 2'b00;
    localparam logic [1:0] KIND_MULH   = 2'b01;
    localparam logic [1:0] KIND_MULHSU = 2'b10;
    localparam logic [1:0] KIND_MULHU  = 2'b11;

    typedef struct packed {
        logic       is_div;
        logic [1:0] kind;
    } mul_op_t;

    typedef struct packed {
        logic is_div;
        logic rem;
        logic uns;
    } div_op_t;

    // same 3 bits, top bit steers to the unit
    typedef union packed {
        mul_op_t mul;
        div_op_t div;
    } intm_op_t;

    typedef struct packed {
        rob_t     rob;
        phy_t     rs1;
        logic     rs1_rdy;
        phy_t     rs2;
        logic     rs2_rdy;
        phy_t     rd;
        intm_op_t op;
    } rs_entry_t;

    typedef struct packed {
        rob_t                  rob;
        phy_t                  rd;
        intm_op_t              op;
        logic [`INTM_XLEN-1:0] a;
        logic [`INTM_XLEN-1:0] b;
    } iss_t;

    typedef struct packed {
        rob_t                  rob;
        phy_t                  rd;
        logic [`INTM_XLEN-1:0] value;
    } res_t;

endpackage

`default_nettype wire

// File: include/intm_settings.svh
`ifndef INTM_SETTINGS_SVH
`define INTM_SETTINGS_SVH

// datapath width
`define INTM_XLEN       32

// physical registers, power of two
`define INTM_PRF_DEPTH  64

// reservation station entries
`define INTM_RS_DEPTH   4

// rob id bits
`define INTM_ROB_W      5

`endif
